// ==== flit_router_defines.svh ====
/*
 * Sizes shared by the router slice and its testbench.
 * Include this header wherever a size macro is needed.
 */
`ifndef FLIT_ROUTER_DEFINES_SVH
`define FLIT_ROUTER_DEFINES_SVH

// number of input ports into the slice
`define FR_NUM_IN    2
// virtual channels per port
`define FR_NUM_VC    2
// entries per VC FIFO, also the upstream credit per VC
`define FR_VC_DEPTH  3
// downstream buffer entries per VC, the initial output credit
`define FR_DS_DEPTH  3
// field widths
`define FR_TAG_W     6
`define FR_PAYLOAD_W 16

`endif

// ==== flit_router_pkg.sv ====
/*
 * Flit, header and index types of the router slice.
 * Referenced with scoped names by the RTL and the testbench.
 */
`include "flit_router_defines.svh"

package flit_router_pkg;

  // VC and input indices
  typedef logic [$clog2(`FR_NUM_VC)-1:0] vc_id_t;
  typedef logic [$clog2(`FR_NUM_IN)-1:0] in_id_t;

  // header travels through the SA stage, tag is carried unchanged
  typedef struct packed {
    vc_id_t              vc_id;
    logic [`FR_TAG_W-1:0] tag;
  } hdr_t;

  typedef logic [`FR_PAYLOAD_W-1:0] payload_t;

  // header in the upper bits, payload below
  typedef struct packed {
    hdr_t     hdr;
    payload_t payload;
  } flit_t;

  // holds 0 up to FR_DS_DEPTH
  typedef logic [$clog2(`FR_DS_DEPTH+1)-1:0] credit_cnt_t;

endpackage

// ==== vc_fifo.sv ====
/*
 * Small synchronous FIFO with a type-parameterized entry.
 * The oldest entry is always visible on head_o while head_v_o is high.
 */
module vc_fifo #(
  parameter int  DEPTH   = 3,
  parameter type entry_t = logic
) (
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  logic   push_i,
  input  entry_t data_i,
  input  logic   pop_i,
  output entry_t head_o,
  output logic   head_v_o,
  output logic   full_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  entry_t           mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign head_v_o = (count != '0);
  assign full_o   = (count == CNT_W'(DEPTH));
  // an overflowing push is dropped so the count stays consistent
  assign do_push  = push_i && !full_o;
  assign do_pop   = pop_i && head_v_o;
  assign head_o   = mem[rd_ptr];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_next(wr_ptr);
      if (do_pop)  rd_ptr <= ptr_next(rd_ptr);
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem[wr_ptr] <= data_i;
  end

endmodule

// ==== flit_input_port.sv ====
/*
 * One input port: a header FIFO and a payload FIFO per VC.
 * Headers leave at switch allocation, payloads at switch traversal,
 * and every payload pop returns one credit upstream.
 */
`include "flit_router_defines.svh"

module flit_input_port (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  logic                                          data_v_i,
  input  flit_router_pkg::flit_t                        data_i,
  output logic                     [`FR_NUM_VC-1:0]     head_v_o,
  output flit_router_pkg::hdr_t    [`FR_NUM_VC-1:0]     head_hdr_o,
  output flit_router_pkg::payload_t [`FR_NUM_VC-1:0]    head_payload_o,
  input  logic                                          sa_pop_i,
  input  flit_router_pkg::vc_id_t                       sa_vc_i,
  input  logic                                          st_pop_i,
  input  flit_router_pkg::vc_id_t                       st_vc_i,
  output logic                                          credit_v_o,
  output flit_router_pkg::vc_id_t                       credit_id_o
);

  logic [`FR_NUM_VC-1:0] push_oh;
  logic [`FR_NUM_VC-1:0] hdr_pop_oh;
  logic [`FR_NUM_VC-1:0] pl_pop_oh;

  // steer the incoming flit by its VC id
  always_comb begin
    push_oh = '0;
    if (data_v_i) push_oh[data_i.hdr.vc_id] = 1'b1;
  end

  always_comb begin
    hdr_pop_oh          = '0;
    hdr_pop_oh[sa_vc_i] = sa_pop_i;
    pl_pop_oh           = '0;
    pl_pop_oh[st_vc_i]  = st_pop_i;
  end

  for (genvar v = 0; v < `FR_NUM_VC; v++) begin : gen_vc
    vc_fifo #(
      .DEPTH   (`FR_VC_DEPTH),
      .entry_t (flit_router_pkg::hdr_t)
    ) u_hdr_fifo (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .push_i   (push_oh[v]),
      .data_i   (data_i.hdr),
      .pop_i    (hdr_pop_oh[v]),
      .head_o   (head_hdr_o[v]),
      .head_v_o (head_v_o[v]),
      .full_o   ()
    );

    // payload head is read one cycle after its header has left
    vc_fifo #(
      .DEPTH   (`FR_VC_DEPTH),
      .entry_t (flit_router_pkg::payload_t)
    ) u_pl_fifo (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .push_i   (push_oh[v]),
      .data_i   (data_i.payload),
      .pop_i    (pl_pop_oh[v]),
      .head_o   (head_payload_o[v]),
      .head_v_o (),
      .full_o   ()
    );
  end

  assign credit_v_o  = st_pop_i;
  assign credit_id_o = st_vc_i;

endmodule

// ==== output_credit_tracker.sv ====
/*
 * Downstream credit counters, one per VC.
 * A grant takes a credit, a downstream return gives one back.
 */
`include "flit_router_defines.svh"

module output_credit_tracker (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          take_v_i,
  input  flit_router_pkg::vc_id_t       take_vc_i,
  input  logic                          ret_v_i,
  input  flit_router_pkg::vc_id_t       ret_vc_i,
  output logic         [`FR_NUM_VC-1:0] has_credit_o
);

  for (genvar v = 0; v < `FR_NUM_VC; v++) begin : gen_cnt
    flit_router_pkg::credit_cnt_t cnt;
    logic                         take;
    logic                         ret;

    assign take = take_v_i && (take_vc_i == flit_router_pkg::vc_id_t'(v));
    assign ret  = ret_v_i && (ret_vc_i == flit_router_pkg::vc_id_t'(v));

    // take and return in the same cycle leave the count unchanged
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        cnt <= flit_router_pkg::credit_cnt_t'(`FR_DS_DEPTH);
      end else if (take && !ret) begin
        cnt <= cnt - 1'b1;
      end else if (ret && !take) begin
        cnt <= cnt + 1'b1;
      end
    end

    assign has_credit_o[v] = (cnt != '0);
  end

endmodule

// ==== switch_allocator.sv ====
/*
 * Switch allocator: round robin over (input, VC) heads whose VC has credit.
 * The grant pops the header and is registered into the ST stage.
 */
`include "flit_router_defines.svh"

module switch_allocator (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  input  logic                  [`FR_NUM_IN-1:0][`FR_NUM_VC-1:0] head_v_i,
  input  flit_router_pkg::hdr_t [`FR_NUM_IN-1:0][`FR_NUM_VC-1:0] head_hdr_i,
  input  logic                  [`FR_NUM_VC-1:0]                 has_credit_i,
  output logic                  [`FR_NUM_IN-1:0]                 sa_pop_o,
  output flit_router_pkg::vc_id_t                                sa_vc_o,
  output logic                                                  take_v_o,
  output flit_router_pkg::vc_id_t                                take_vc_o,
  output logic                                                  st_v_o,
  output flit_router_pkg::in_id_t                                st_in_o,
  output flit_router_pkg::vc_id_t                                st_vc_o,
  output flit_router_pkg::hdr_t                                  st_hdr_o
);

  localparam int NUM_REQ = `FR_NUM_IN * `FR_NUM_VC;
  localparam int REQ_W   = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1;

  logic [NUM_REQ-1:0]      req;
  logic [REQ_W-1:0]        rr_ptr;
  logic                    gnt_v;
  logic [REQ_W-1:0]        gnt_idx;
  flit_router_pkg::in_id_t gnt_in;
  flit_router_pkg::vc_id_t gnt_vc;

  // requester index is input * FR_NUM_VC + vc
  always_comb begin
    for (int i = 0; i < `FR_NUM_IN; i++) begin
      for (int v = 0; v < `FR_NUM_VC; v++) begin
        req[i*`FR_NUM_VC+v] = head_v_i[i][v] && has_credit_i[v];
      end
    end
  end

  // first requester at or after the pointer, wrapping around
  always_comb begin
    int pos;
    gnt_v   = 1'b0;
    gnt_idx = '0;
    for (int k = 0; k < NUM_REQ; k++) begin
      pos = int'(rr_ptr) + k;
      if (pos >= NUM_REQ) pos = pos - NUM_REQ;
      if (!gnt_v && req[pos]) begin
        gnt_v   = 1'b1;
        gnt_idx = REQ_W'(pos);
      end
    end
  end

  assign gnt_in = flit_router_pkg::in_id_t'(gnt_idx / `FR_NUM_VC);
  assign gnt_vc = flit_router_pkg::vc_id_t'(gnt_idx % `FR_NUM_VC);

  always_comb begin
    for (int i = 0; i < `FR_NUM_IN; i++) begin
      sa_pop_o[i] = gnt_v && (gnt_in == flit_router_pkg::in_id_t'(i));
    end
  end

  assign sa_vc_o   = gnt_vc;
  assign take_v_o  = gnt_v;
  assign take_vc_o = gnt_vc;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_ptr <= '0;
      st_v_o <= 1'b0;
    end else begin
      st_v_o <= gnt_v;
      if (gnt_v) rr_ptr <= (gnt_idx == REQ_W'(NUM_REQ - 1)) ? '0 : gnt_idx + 1'b1;
    end
  end

  // ST stage fields, qualified by st_v_o
  always_ff @(posedge clk_i) begin
    if (gnt_v) begin
      st_in_o  <= gnt_in;
      st_vc_o  <= gnt_vc;
      st_hdr_o <= head_hdr_i[gnt_in][gnt_vc];
    end
  end

endmodule

// ==== switch_traversal.sv ====
/*
 * Switch traversal: picks the granted payload head and joins it
 * to the registered header in the output flit register.
 */
`include "flit_router_defines.svh"

module switch_traversal (
  input  logic                                                      clk_i,
  input  logic                                                      rst_n_i,
  input  logic                                                      st_v_i,
  input  flit_router_pkg::in_id_t                                    st_in_i,
  input  flit_router_pkg::hdr_t                                      st_hdr_i,
  input  flit_router_pkg::payload_t [`FR_NUM_IN-1:0][`FR_NUM_VC-1:0] head_payload_i,
  output logic                                                      out_v_o,
  output flit_router_pkg::flit_t                                     out_flit_o
);

  flit_router_pkg::payload_t st_payload;

  // VC comes from the header that won allocation
  assign st_payload = head_payload_i[st_in_i][st_hdr_i.vc_id];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_v_o <= 1'b0;
    end else begin
      out_v_o <= st_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (st_v_i) begin
      out_flit_o.hdr     <= st_hdr_i;
      out_flit_o.payload <= st_payload;
    end
  end

endmodule

// ==== flit_router.sv ====
/*
 * Top level of the router output slice.
 * Connects the input ports, the allocator, the credit tracker and the ST stage.
 */
`include "flit_router_defines.svh"

module flit_router (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  logic                    [`FR_NUM_IN-1:0]      data_v_i,
  input  flit_router_pkg::flit_t  [`FR_NUM_IN-1:0]      data_i,
  output logic                    [`FR_NUM_IN-1:0]      credit_v_o,
  output flit_router_pkg::vc_id_t [`FR_NUM_IN-1:0]      credit_id_o,
  input  logic                                          ds_credit_v_i,
  input  flit_router_pkg::vc_id_t                       ds_credit_id_i,
  output logic                                          out_v_o,
  output flit_router_pkg::flit_t                        out_flit_o
);

  logic                      [`FR_NUM_IN-1:0][`FR_NUM_VC-1:0] head_v;
  flit_router_pkg::hdr_t     [`FR_NUM_IN-1:0][`FR_NUM_VC-1:0] head_hdr;
  flit_router_pkg::payload_t [`FR_NUM_IN-1:0][`FR_NUM_VC-1:0] head_payload;
  logic                      [`FR_NUM_IN-1:0]                 sa_pop;
  logic                      [`FR_NUM_IN-1:0]                 st_pop;
  logic                      [`FR_NUM_VC-1:0]                 has_credit;
  flit_router_pkg::vc_id_t                                    sa_vc;
  logic                                                       take_v;
  flit_router_pkg::vc_id_t                                    take_vc;
  logic                                                       st_v;
  flit_router_pkg::in_id_t                                    st_in;
  flit_router_pkg::vc_id_t                                    st_vc;
  flit_router_pkg::hdr_t                                      st_hdr;

  for (genvar i = 0; i < `FR_NUM_IN; i++) begin : gen_in
    // only the input that won allocation sees the payload pop
    assign st_pop[i] = st_v && (st_in == flit_router_pkg::in_id_t'(i));

    flit_input_port u_in_port (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .data_v_i       (data_v_i[i]),
      .data_i         (data_i[i]),
      .head_v_o       (head_v[i]),
      .head_hdr_o     (head_hdr[i]),
      .head_payload_o (head_payload[i]),
      .sa_pop_i       (sa_pop[i]),
      .sa_vc_i        (sa_vc),
      .st_pop_i       (st_pop[i]),
      .st_vc_i        (st_vc),
      .credit_v_o     (credit_v_o[i]),
      .credit_id_o    (credit_id_o[i])
    );
  end

  switch_allocator u_sa (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .head_v_i     (head_v),
    .head_hdr_i   (head_hdr),
    .has_credit_i (has_credit),
    .sa_pop_o     (sa_pop),
    .sa_vc_o      (sa_vc),
    .take_v_o     (take_v),
    .take_vc_o    (take_vc),
    .st_v_o       (st_v),
    .st_in_o      (st_in),
    .st_vc_o      (st_vc),
    .st_hdr_o     (st_hdr)
  );

  output_credit_tracker u_credit (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .take_v_i     (take_v),
    .take_vc_i    (take_vc),
    .ret_v_i      (ds_credit_v_i),
    .ret_vc_i     (ds_credit_id_i),
    .has_credit_o (has_credit)
  );

  switch_traversal u_st (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .st_v_i         (st_v),
    .st_in_i        (st_in),
    .st_hdr_i       (st_hdr),
    .head_payload_i (head_payload),
    .out_v_o        (out_v_o),
    .out_flit_o     (out_flit_o)
  );

endmodule

// ==== flit_router_assert.sv ====
/*
 * Concurrent checks on the router slice, bound into the top level.
 * Covers VC FIFO overflow, the output during reset and the downstream credit rules.
 */
`include "flit_router_defines.svh"

module flit_router_assert (
  input logic                                            clk_i,
  input logic                                            rst_n_i,
  input logic                         [`FR_NUM_IN-1:0]   data_v_i,
  input flit_router_pkg::flit_t       [`FR_NUM_IN-1:0]   data_i,
  input logic               [`FR_NUM_IN*`FR_NUM_VC-1:0]  fifo_full_i,
  input logic                                            out_v_i,
  input logic                                            take_v_i,
  input flit_router_pkg::vc_id_t                         take_vc_i,
  input logic                                            ret_v_i,
  input flit_router_pkg::vc_id_t                         ret_vc_i,
  input flit_router_pkg::credit_cnt_t [`FR_NUM_VC-1:0]   cnt_i
);

  logic push_full;

  // the payload FIFO drains later than its header FIFO and fills first
  always_comb begin
    push_full = 1'b0;
    for (int i = 0; i < `FR_NUM_IN; i++) begin
      if (data_v_i[i] && fifo_full_i[i*`FR_NUM_VC+int'(data_i[i].hdr.vc_id)]) begin
        push_full = 1'b1;
      end
    end
  end

  a_no_full_push: assert property (@(posedge clk_i) disable iff (!rst_n_i) !push_full)
    else $error("flit pushed into a full VC FIFO");

  a_out_reset: assert property (@(posedge clk_i) !rst_n_i |-> !out_v_i)
    else $error("output valid while reset is held");

  a_grant_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    take_v_i |-> (cnt_i[take_vc_i] != '0))
    else $error("grant to a VC without downstream credit");

  for (genvar v = 0; v < `FR_NUM_VC; v++) begin : gen_cnt
    logic take;
    logic ret;

    assign take = take_v_i && (take_vc_i == flit_router_pkg::vc_id_t'(v));
    assign ret  = ret_v_i && (ret_vc_i == flit_router_pkg::vc_id_t'(v));

    // a lone return on a full counter would push it past the buffer depth
    a_cnt_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (ret && !take) |-> (int'(cnt_i[v]) < `FR_DS_DEPTH))
      else $error("downstream credit count above buffer depth");
  end

endmodule

bind flit_router flit_router_assert u_assert (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .data_v_i     (data_v_i),
  .data_i       (data_i),
  .fifo_full_i  ({gen_in[1].u_in_port.gen_vc[1].u_pl_fifo.full_o,
                  gen_in[1].u_in_port.gen_vc[0].u_pl_fifo.full_o,
                  gen_in[0].u_in_port.gen_vc[1].u_pl_fifo.full_o,
                  gen_in[0].u_in_port.gen_vc[0].u_pl_fifo.full_o}),
  .out_v_i      (out_v_o),
  .take_v_i     (take_v),
  .take_vc_i    (take_vc),
  .ret_v_i      (ds_credit_v_i),
  .ret_vc_i     (ds_credit_id_i),
  .cnt_i        ({u_credit.gen_cnt[1].cnt, u_credit.gen_cnt[0].cnt})
);

// ==== flit_router_tb.sv ====
/*
 * Directed testbench for the router output slice.
 * Plays the upstream routers and the downstream buffer, keeps the expected
 * flits per (input, VC) and checks order, credits and arbitration.
 */
`include "flit_router_defines.svh"

module flit_router_tb;

  localparam int NUM_REQ     = `FR_NUM_IN * `FR_NUM_VC;
  localparam int REQ_W       = $clog2(NUM_REQ);
  localparam int TIMEOUT_CYC = 2000;

  logic                                     clk_i;
  logic                                     rst_n_i;
  logic                    [`FR_NUM_IN-1:0] data_v_i;
  flit_router_pkg::flit_t  [`FR_NUM_IN-1:0] data_i;
  logic                    [`FR_NUM_IN-1:0] credit_v_o;
  flit_router_pkg::vc_id_t [`FR_NUM_IN-1:0] credit_id_o;
  logic                                     ds_credit_v_i;
  flit_router_pkg::vc_id_t                  ds_credit_id_i;
  logic                                     out_v_o;
  flit_router_pkg::flit_t                   out_flit_o;

  // scoreboard queues per requester number input * FR_NUM_VC + vc
  flit_router_pkg::flit_t  exp_q [NUM_REQ][$];
  flit_router_pkg::vc_id_t cred_q [`FR_NUM_IN][$];
  flit_router_pkg::in_id_t out_in_q [$];
  int                      up_cred [`FR_NUM_IN][`FR_NUM_VC];
  int                      ds_pending [`FR_NUM_VC];
  int                      sent [`FR_NUM_IN];
  logic [`FR_TAG_W-2:0]    seq [`FR_NUM_IN];
  logic [REQ_W-1:0]        rr_model;
  // mode 0 holds downstream credits while 1 returns one per cycle and 2 returns at random
  int                      ds_mode;
  int                      cycle_cnt;
  logic [31:0]             lfsr_state;
  string                   test_name;

  flit_router dut (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .data_v_i       (data_v_i),
    .data_i         (data_i),
    .credit_v_o     (credit_v_o),
    .credit_id_o    (credit_id_o),
    .ds_credit_v_i  (ds_credit_v_i),
    .ds_credit_id_i (ds_credit_id_i),
    .out_v_o        (out_v_o),
    .out_flit_o     (out_flit_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // galois LFSR stepped once per bit
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) lfsr_state = lfsr_state ^ 32'hD000_0001;
    return b;
  endfunction

  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  function automatic logic [REQ_W-1:0] req_of(input flit_router_pkg::in_id_t in,
                                              input flit_router_pkg::vc_id_t vc);
    return REQ_W'(int'(in) * `FR_NUM_VC + int'(vc));
  endfunction

  function automatic int busy_total();
    int n;
    n = 0;
    for (int r = 0; r < NUM_REQ; r++) n += exp_q[r].size();
    for (int v = 0; v < `FR_NUM_VC; v++) n += ds_pending[v];
    return n;
  endfunction

  task automatic check_flit(input string name, input flit_router_pkg::flit_t exp,
                            input flit_router_pkg::flit_t act);
    if (act !== exp) begin
      report_failure($sformatf("FAILED %s: expected flit %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_credit(input string name, input flit_router_pkg::vc_id_t exp,
                              input flit_router_pkg::vc_id_t act);
    if (act !== exp) begin
      report_failure($sformatf("FAILED %s: expected credit vc %0d, actual %0d",
                               name, exp, act));
    end
  endtask

  task automatic check_in(input string name, input flit_router_pkg::in_id_t exp,
                          input flit_router_pkg::in_id_t act);
    if (act !== exp) begin
      report_failure($sformatf("FAILED %s: expected input %0d, actual %0d", name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      report_failure($sformatf("FAILED %s: expected count %0d, actual %0d", name, exp, act));
    end
  endtask

  // outputs are sampled mid-cycle where everything is settled
  task automatic sample_outputs();
    logic [REQ_W-1:0]        idx;
    flit_router_pkg::in_id_t src;
    if (out_v_o) begin
      src = flit_router_pkg::in_id_t'(out_flit_o.hdr.tag[`FR_TAG_W-1]);
      idx = req_of(src, out_flit_o.hdr.vc_id);
      if (exp_q[idx].size() == 0) begin
        report_failure($sformatf("unexpected flit %h on the output in %s",
                                 out_flit_o, test_name));
      end else begin
        check_flit(test_name, exp_q[idx].pop_front(), out_flit_o);
      end
      ds_pending[out_flit_o.hdr.vc_id]++;
      out_in_q.push_back(src);
      // pointer moves to the granted requester plus one
      rr_model = REQ_W'((int'(idx) + 1) % NUM_REQ);
    end
    for (int i = 0; i < `FR_NUM_IN; i++) begin
      if (credit_v_o[i]) begin
        cred_q[i].push_back(credit_id_o[i]);
        up_cred[i][credit_id_o[i]]++;
        if (up_cred[i][credit_id_o[i]] > `FR_VC_DEPTH) begin
          report_failure($sformatf("input %0d returned a credit for no buffered flit", i));
        end
      end
    end
  endtask

  initial begin
    forever begin
      @(negedge clk_i);
      if (rst_n_i) sample_outputs();
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYC) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    report_failure($sformatf("timeout: tests did not finish in %0d cycles", TIMEOUT_CYC));
  end

  // advance one cycle and drive the downstream credit for it
  task automatic next_cycle();
    logic go;
    @(posedge clk_i);
    #1;
    data_v_i      = '0;
    ds_credit_v_i = 1'b0;
    go            = 1'b0;
    if (ds_mode == 1) go = 1'b1;
    if (ds_mode == 2) go = lfsr_bit();
    if (go) begin
      for (int v = 0; v < `FR_NUM_VC; v++) begin
        if (!ds_credit_v_i && ds_pending[v] > 0) begin
          ds_credit_v_i  = 1'b1;
          ds_credit_id_i = flit_router_pkg::vc_id_t'(v);
          ds_pending[v]--;
        end
      end
    end
  endtask

  // tag holds the input in its top bit and a sequence number below
  task automatic drive_flit(input flit_router_pkg::in_id_t in,
                            input flit_router_pkg::vc_id_t vc,
                            input flit_router_pkg::payload_t pl);
    flit_router_pkg::flit_t f;
    f.hdr.vc_id  = vc;
    f.hdr.tag    = {in, seq[in]};
    f.payload    = pl;
    data_v_i[in] = 1'b1;
    data_i[in]   = f;
    up_cred[in][vc]--;
    sent[in]++;
    seq[in]++;
    exp_q[req_of(in, vc)].push_back(f);
  endtask

  task automatic send_flit(input flit_router_pkg::in_id_t in,
                           input flit_router_pkg::vc_id_t vc);
    while (up_cred[in][vc] == 0) next_cycle();
    drive_flit(in, vc, flit_router_pkg::payload_t'(lfsr_bits(`FR_PAYLOAD_W)));
    next_cycle();
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    $display("running %s", name);
    for (int i = 0; i < `FR_NUM_IN; i++) begin
      sent[i] = 0;
      cred_q[i].delete();
    end
    out_in_q.delete();
  endtask

  // drain with downstream credits flowing and check the upstream credits
  task automatic end_test();
    int idle;
    idle    = 0;
    ds_mode = 1;
    while (idle < 4) begin
      next_cycle();
      idle = (busy_total() == 0) ? idle + 1 : 0;
    end
    for (int i = 0; i < `FR_NUM_IN; i++) begin
      check_count(test_name, sent[i], cred_q[i].size());
      for (int v = 0; v < `FR_NUM_VC; v++) check_count(test_name, `FR_VC_DEPTH, up_cred[i][v]);
    end
  endtask

  task automatic single_flit();
    begin_test("single_flit");
    send_flit(1'b0, 1'b1);
    end_test();
    check_credit(test_name, 1'b1, cred_q[0][0]);
  endtask

  task automatic vc_order();
    begin_test("vc_order");
    for (int k = 0; k < 3; k++) begin
      send_flit(1'b1, 1'b0);
      send_flit(1'b1, 1'b1);
    end
    end_test();
  endtask

  task automatic credit_stall();
    begin_test("credit_stall");
    ds_mode = 0;
    for (int k = 0; k < `FR_DS_DEPTH + 2; k++) send_flit(1'b0, 1'b0);
    for (int k = 0; k < `FR_DS_DEPTH; k++) send_flit(1'b0, 1'b1);
    while (exp_q[req_of(1'b0, 1'b1)].size() != 0) next_cycle();
    // VC 0 must stay blocked while no credit comes back
    repeat (8) next_cycle();
    check_count(test_name, 2, exp_q[req_of(1'b0, 1'b0)].size());
    end_test();
  endtask

  task automatic round_robin();
    flit_router_pkg::in_id_t first;
    begin_test("round_robin");
    // input 0 VC 0 is requester 0 and input 1 VC 0 is requester FR_NUM_VC
    first = (rr_model != '0 && int'(rr_model) <= `FR_NUM_VC) ? 1'b1 : 1'b0;
    for (int k = 0; k < 3; k++) begin
      drive_flit(1'b0, 1'b0, flit_router_pkg::payload_t'(lfsr_bits(`FR_PAYLOAD_W)));
      drive_flit(1'b1, 1'b0, flit_router_pkg::payload_t'(lfsr_bits(`FR_PAYLOAD_W)));
      next_cycle();
    end
    end_test();
    check_count(test_name, 6, out_in_q.size());
    for (int k = 0; k < 6; k++) begin
      check_in(test_name, first ^ flit_router_pkg::in_id_t'(k % 2), out_in_q[k]);
    end
  endtask

  task automatic random_traffic();
    flit_router_pkg::vc_id_t vc;
    begin_test("random_traffic");
    ds_mode = 2;
    repeat (150) begin
      for (int i = 0; i < `FR_NUM_IN; i++) begin
        if (lfsr_bit()) begin
          vc = flit_router_pkg::vc_id_t'(lfsr_bit());
          if (up_cred[i][vc] > 0) begin
            drive_flit(flit_router_pkg::in_id_t'(i), vc,
                       flit_router_pkg::payload_t'(lfsr_bits(`FR_PAYLOAD_W)));
          end
        end
      end
      next_cycle();
    end
    end_test();
  endtask

  initial begin
    lfsr_state     = 32'd94326;
    rst_n_i        = 1'b0;
    data_v_i       = '0;
    data_i         = '0;
    ds_credit_v_i  = 1'b0;
    ds_credit_id_i = '0;
    ds_mode        = 1;
    rr_model       = '0;
    test_name      = "reset";
    for (int i = 0; i < `FR_NUM_IN; i++) begin
      sent[i] = 0;
      seq[i]  = '0;
      for (int v = 0; v < `FR_NUM_VC; v++) up_cred[i][v] = `FR_VC_DEPTH;
    end
    for (int v = 0; v < `FR_NUM_VC; v++) ds_pending[v] = 0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    single_flit();
    vc_order();
    credit_stall();
    round_robin();
    random_traffic();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== flit_router.f ====
+incdir+.
flit_router_pkg.sv
vc_fifo.sv
flit_input_port.sv
output_credit_tracker.sv
switch_allocator.sv
switch_traversal.sv
flit_router.sv
flit_router_assert.sv
flit_router_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = flit_router_tb
FILELIST  = flit_router.f
LOG       = sim.log
PASS_MSG  = TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
